//--- tb.f
rom_load_pkg.sv
rom_region_decode.sv
sdram_port_writer.sv
rom_load_status.sv
rom_loader_top.sv
rom_loader_assertions.sv
tb_rom_loader.sv

//--- tb_rom_loader.sv
/*
 * Testbench for the ROM download subsystem
 *   Stimulus table of download bytes applied in a loop
 *   Toggle and pulse monitor, compare tasks and cycle timeout
 *   Load status and game reset sequence
 */
`timescale 1ns/10ps

module tb_rom_loader;
	import rom_load_pkg::*;

	localparam logic [15:0] RESET_CYCLES = 16'd16;

	// One downloaded byte where a negative data argument asks for random data
	typedef struct packed {
		logic [24:0] addr;
		logic [7:0]  data;
		logic        fixed;
		logic [3:0]  hold;
		logic        download;
		rom_region_e dest;
	} stim_t;

	logic        clk_sd;
	logic        rst;
	logic        download;
	logic        wr;
	logic [24:0] addr;
	logic [7:0]  data;
	logic        reset_request;
	logic        port1_req;
	logic        port2_req;
	logic        port_we;
	logic        pal_strobe;
	logic        rom_loaded;
	logic        game_reset;
	port_wr_t    port1_wr;
	port_wr_t    port2_wr;
	pal_wr_t     pal_wr;

	stim_t    stim_q[$];
	integer   seed;
	int       checks;
	int       errors;
	int       other_errors;
	int       cycles;
	int       timeout_limit;
	int       p1_toggles;
	int       p2_toggles;
	int       pal_pulses;
	logic     p1_last;
	logic     p2_last;
	int       exp_p1_count;
	int       exp_p2_count;
	int       exp_pal_count;
	port_wr_t exp_p1;
	port_wr_t exp_p2;
	pal_wr_t  exp_pal;
	logic     have_p1;
	logic     have_p2;
	logic     have_pal;

	rom_loader_top #(
		.RESET_CYCLES (RESET_CYCLES)
	) u_rom_loader_top (
		.clk_sd        (clk_sd),
		.rst           (rst),
		.download      (download),
		.wr            (wr),
		.addr          (addr),
		.data          (data),
		.reset_request (reset_request),
		.port1_req     (port1_req),
		.port1_wr      (port1_wr),
		.port2_req     (port2_req),
		.port2_wr      (port2_wr),
		.port_we       (port_we),
		.pal_strobe    (pal_strobe),
		.pal_wr        (pal_wr),
		.rom_loaded    (rom_loaded),
		.game_reset    (game_reset)
	);

	always #50 clk_sd = ~clk_sd;

	always @(posedge clk_sd) begin
		cycles++;
		if (cycles > timeout_limit) begin
			$display("ERROR: timeout, the run did not end within %0d cycles", timeout_limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// Outputs are stable at the falling edge, so every edge of req and
	// every cycle of pal_strobe is counted there
	always @(negedge clk_sd) begin
		if (rst) begin
			p1_toggles = 0;
			p2_toggles = 0;
			pal_pulses = 0;
		end else begin
			if (port1_req !== p1_last)
				p1_toggles++;
			if (port2_req !== p2_last)
				p2_toggles++;
			if (pal_strobe)
				pal_pulses++;
		end
		p1_last = port1_req;
		p2_last = port2_req;
	end

	// ======================================================================
	// Compare tasks
	// ======================================================================

	task automatic check_port(input string what, input port_wr_t got, input port_wr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s addr %h ds %b data %h, expected addr %h ds %b data %h",
				$time, what, got.addr, got.ds, got.data, exp.addr, exp.ds, exp.data);
		end
	endtask

	task automatic check_pal(input string what, input pal_wr_t got, input pal_wr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s addr %h data %h, expected addr %h data %h",
				$time, what, got.addr, got.data, exp.addr, exp.data);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// ======================================================================
	// Stimulus
	// ======================================================================

	task automatic add_byte(input logic [24:0] a, input int d, input int hold,
		input logic dl, input rom_region_e dest);
		stim_t s;
		s.addr     = a;
		s.data     = 8'(d);
		s.fixed    = (d >= 0);
		s.hold     = 4'(hold);
		s.download = dl;
		s.dest     = dest;
		stim_q.push_back(s);
	endtask

	task automatic build_table();
		add_byte(25'h000_0000, 'ha5, 1, 1'b1, region_main);
		add_byte(25'h000_0001, -1, 1, 1'b1, region_main);
		add_byte(25'h000_1234, 'h3c, 1, 1'b1, region_main);
		add_byte(25'h000_7fff, -1, 1, 1'b1, region_main);
		add_byte(25'h000_8000, -1, 1, 1'b1, region_sound);
		add_byte(25'h000_9fff, 'hc3, 1, 1'b1, region_sound);
		add_byte(25'h000_a000, -1, 1, 1'b1, region_tile);
		add_byte(25'h000_c347, -1, 1, 1'b1, region_tile);
		add_byte(25'h000_ffff, 'hff, 1, 1'b1, region_tile);
		// Sprite bytes over both lanes and both halves
		add_byte(25'h001_0000, 'h11, 1, 1'b1, region_sprite);
		add_byte(25'h001_4000, -1, 1, 1'b1, region_sprite);
		add_byte(25'h001_8000, -1, 1, 1'b1, region_sprite);
		add_byte(25'h001_bfff, 'h80, 1, 1'b1, region_sprite);
		add_byte(25'h001_2345, -1, 1, 1'b1, region_sprite);
		add_byte(25'h001_7abc, -1, 1, 1'b1, region_sprite);
		add_byte(25'h001_9d2e, -1, 1, 1'b1, region_sprite);
		add_byte(25'h001_c000, 'h01, 1, 1'b1, region_pal);
		add_byte(25'h001_c0ff, -1, 1, 1'b1, region_pal);
		add_byte(25'h001_c200, -1, 1, 1'b1, region_pal);
		add_byte(25'h001_c31f, 'hee, 1, 1'b1, region_pal);
		// A strobe held high still counts as one byte
		add_byte(25'h000_0123, -1, 5, 1'b1, region_main);
		add_byte(25'h001_5555, -1, 5, 1'b1, region_sprite);
		add_byte(25'h001_c100, -1, 5, 1'b1, region_pal);
		add_byte(25'h001_c320, -1, 1, 1'b1, region_none);
		add_byte(25'h001_ffff, -1, 1, 1'b1, region_none);
		add_byte(25'h010_0000, -1, 1, 1'b1, region_none);
		add_byte(25'h1ff_ffff, -1, 1, 1'b1, region_none);
		// Writes without download go nowhere
		add_byte(25'h000_0010, -1, 1, 1'b0, region_none);
		add_byte(25'h001_4000, -1, 1, 1'b0, region_none);
		add_byte(25'h001_c010, -1, 1, 1'b0, region_none);
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (5) @(posedge clk_sd);
		#1;
		rst = 1'b0;
		exp_p1_count  = 0;
		exp_p2_count  = 0;
		exp_pal_count = 0;
		check_bit("port1_req after reset", port1_req, 1'b0);
		check_bit("port2_req after reset", port2_req, 1'b0);
		check_bit("pal_strobe after reset", pal_strobe, 1'b0);
		check_bit("rom_loaded after reset", rom_loaded, 1'b0);
		check_bit("game_reset after reset", game_reset, 1'b1);
	endtask

	task automatic apply_entry(input stim_t s);
		logic [7:0]  d;
		logic [24:0] rel;
		string       tag;
		logic        p1_before;
		logic        p2_before;
		int          k;
		d   = s.fixed ? s.data : 8'($random(seed));
		tag = $sformatf("byte %h", s.addr);
		p1_before = exp_p1_count[0];
		p2_before = exp_p2_count[0];

		case (s.dest)
			region_main, region_sound, region_tile: begin
				exp_p1_count++;
				exp_p1.addr = s.addr[23:1];
				exp_p1.ds   = {s.addr[0], ~s.addr[0]};
				exp_p1.data = {d, d};
				have_p1     = 1'b1;
			end
			region_sprite: begin
				// Upper bits, offset, then the half bit as the lowest word bit
				rel = s.addr - 25'h001_0000;
				exp_p2_count++;
				exp_p2.addr = {rel[23:16], rel[13:0], rel[15]};
				exp_p2.ds   = {rel[14], ~rel[14]};
				exp_p2.data = {d, d};
				have_p2     = 1'b1;
			end
			region_pal: begin
				exp_pal_count++;
				exp_pal.addr = s.addr[16:0];
				exp_pal.data = d;
				have_pal     = 1'b1;
			end
			default: ;
		endcase

		addr     = s.addr;
		data     = d;
		download = s.download;
		wr       = 1'b1;
		// The rising strobe is taken at the first edge and the ports answer two edges later
		for (k = 1; k <= int'(s.hold) + 3; k++) begin
			@(posedge clk_sd);
			#1;
			if (k == int'(s.hold))
				wr = 1'b0;
			if (k == 2) begin
				check_bit({tag, " port1_req early"}, port1_req, p1_before);
				check_bit({tag, " port2_req early"}, port2_req, p2_before);
				check_bit({tag, " pal_strobe early"}, pal_strobe, 1'b0);
			end
			if (k == 3) begin
				check_bit({tag, " port1_req on time"}, port1_req, exp_p1_count[0]);
				check_bit({tag, " port2_req on time"}, port2_req, exp_p2_count[0]);
				check_bit({tag, " pal_strobe on time"}, pal_strobe, s.dest == region_pal);
			end
		end

		check_count({tag, " port1 toggles"}, p1_toggles, exp_p1_count);
		check_count({tag, " port2 toggles"}, p2_toggles, exp_p2_count);
		check_count({tag, " pal_strobe cycles"}, pal_pulses, exp_pal_count);
		check_bit({tag, " port1_req"}, port1_req, exp_p1_count[0]);
		check_bit({tag, " port2_req"}, port2_req, exp_p2_count[0]);
		check_bit({tag, " port_we"}, port_we, s.download);
		if (have_p1)
			check_port({tag, " port1_wr"}, port1_wr, exp_p1);
		if (have_p2)
			check_port({tag, " port2_wr"}, port2_wr, exp_p2);
		if (have_pal)
			check_pal({tag, " pal_wr"}, pal_wr, exp_pal);
	endtask

	// Counts cycles from the last counter reload until game_reset drops
	task automatic measure_reset_release(input string what);
		int n;
		n = 0;
		while (game_reset !== 1'b0 && n <= 100) begin
			@(posedge clk_sd);
			#1;
			n++;
		end
		if (game_reset !== 1'b0) begin
			other_errors++;
			$display("ERROR: game_reset did not fall within %0d cycles %s", n, what);
		end else begin
			check_count({"game_reset release ", what}, n, int'(RESET_CYCLES) + 1);
		end
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin
		clk_sd        = 1'b0;
		rst           = 1'b1;
		download      = 1'b0;
		wr            = 1'b0;
		addr          = '0;
		data          = '0;
		reset_request = 1'b0;
		seed          = 32'he118_17ea;
		checks        = 0;
		errors        = 0;
		other_errors  = 0;
		cycles        = 0;
		have_p1       = 1'b0;
		have_p2       = 1'b0;
		have_pal      = 1'b0;
		build_table();
		timeout_limit = stim_q.size() * 8 + int'(RESET_CYCLES) + 50;

		apply_reset();
		download = 1'b1;
		@(posedge clk_sd);
		#1;
		foreach (stim_q[i])
			apply_entry(stim_q[i]);

		// Fresh start for the end of download and the game reset counter
		apply_reset();
		download = 1'b1;
		repeat (3) @(posedge clk_sd);
		#1;
		download = 1'b0;
		check_bit("rom_loaded before download end", rom_loaded, 1'b0);
		@(posedge clk_sd);
		#1;
		check_bit("rom_loaded after download end", rom_loaded, 1'b1);
		measure_reset_release("after download");
		reset_request = 1'b1;
		repeat (4) @(posedge clk_sd);
		#1;
		check_bit("game_reset while reset_request", game_reset, 1'b1);
		reset_request = 1'b0;
		measure_reset_release("after reset_request");
		check_bit("rom_loaded held", rom_loaded, 1'b1);

		$display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, errors, other_errors);
		if (errors == 0 && other_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- rom_loader_assertions.sv
/*
 * Concurrent checks on the SDRAM port writer
 *   Request edges follow a valid command of their region
 *   Palette pulse lasts one cycle
 *   Valid commands are spaced three cycles or more
 */
`timescale 1ns/10ps

module rom_loader_assertions (
	input logic                  clk_sd,
	input logic                  rst,
	input rom_load_pkg::dl_cmd_t cmd,
	input logic                  port1_req,
	input logic                  port2_req,
	input logic                  pal_strobe
);
	import rom_load_pkg::*;

	logic port1_cmd;
	logic port2_cmd;

	assign port1_cmd = cmd.valid && (cmd.region == region_main ||
		cmd.region == region_sound || cmd.region == region_tile);
	assign port2_cmd = cmd.valid && (cmd.region == region_sprite);

	port1_toggle: assert property (@(posedge clk_sd) disable iff (rst)
		$changed(port1_req) |-> $past(port1_cmd))
		else $error("port1_req changed without a port 1 command");

	port2_toggle: assert property (@(posedge clk_sd) disable iff (rst)
		$changed(port2_req) |-> $past(port2_cmd))
		else $error("port2_req changed without a sprite command");

	pal_pulse: assert property (@(posedge clk_sd) disable iff (rst)
		pal_strobe |=> !pal_strobe)
		else $error("pal_strobe stayed high for two cycles");

	// There is no back-pressure, so the source has to keep this spacing
	cmd_spacing: assert property (@(posedge clk_sd) disable iff (rst)
		cmd.valid |=> !cmd.valid [*2])
		else $error("valid commands closer than three cycles");

endmodule

bind sdram_port_writer rom_loader_assertions u_rom_loader_assertions (
	.clk_sd     (clk_sd),
	.rst        (rst),
	.cmd        (cmd),
	.port1_req  (port1_req),
	.port2_req  (port2_req),
	.pal_strobe (pal_strobe)
);

//--- rom_loader_top.sv
/*
 * ROM download subsystem
 * Byte decoder, SDRAM port writer and load status on the SDRAM clock
 */
`timescale 1ns/10ps

module rom_loader_top #(
	parameter logic [15:0] RESET_CYCLES = 16'hffff
) (
	input  logic                   clk_sd,
	input  logic                   rst,
	input  logic                   download,
	input  logic                   wr,
	input  logic [24:0]            addr,
	input  logic [7:0]             data,
	input  logic                   reset_request,
	output logic                   port1_req,
	output rom_load_pkg::port_wr_t port1_wr,
	output logic                   port2_req,
	output rom_load_pkg::port_wr_t port2_wr,
	output logic                   port_we,
	output logic                   pal_strobe,
	output rom_load_pkg::pal_wr_t  pal_wr,
	output logic                   rom_loaded,
	output logic                   game_reset
);
	import rom_load_pkg::*;

	dl_cmd_t cmd;

	// Both ports only ever write while a download is running
	assign port_we = download;

	rom_region_decode u_rom_region_decode (
		.clk_sd   (clk_sd),
		.rst      (rst),
		.download (download),
		.wr       (wr),
		.addr     (addr),
		.data     (data),
		.cmd      (cmd)
	);

	sdram_port_writer u_sdram_port_writer (
		.clk_sd     (clk_sd),
		.rst        (rst),
		.cmd        (cmd),
		.port1_req  (port1_req),
		.port2_req  (port2_req),
		.pal_strobe (pal_strobe),
		.port1_wr   (port1_wr),
		.port2_wr   (port2_wr),
		.pal_wr     (pal_wr)
	);

	rom_load_status #(
		.RESET_CYCLES (RESET_CYCLES)
	) u_rom_load_status (
		.clk_sd        (clk_sd),
		.rst           (rst),
		.download      (download),
		.reset_request (reset_request),
		.rom_loaded    (rom_loaded),
		.game_reset    (game_reset)
	);

endmodule

//--- rom_load_status.sv
/*
 * Download status and game reset
 * Flags the ROM as loaded when the download ends and holds the game
 * in reset for a programmable number of cycles
 */
`timescale 1ns/10ps

module rom_load_status #(
	parameter logic [15:0] RESET_CYCLES = 16'hffff
) (
	input  logic clk_sd,
	input  logic rst,
	input  logic download,
	input  logic reset_request,
	output logic rom_loaded,
	output logic game_reset
);

	logic        download_q;
	logic [15:0] reset_count;

	// Loaded on the falling edge of download, only rst clears it
	always_ff @(posedge clk_sd) begin
		if (rst) begin
			download_q <= 1'b0;
			rom_loaded <= 1'b0;
		end else begin
			download_q <= download;
			if (download_q && !download)
				rom_loaded <= 1'b1;
		end
	end

	// ======================================================================
	// Reset counter
	// ======================================================================

	// Reload while nothing is loaded or the user asks for a reset
	always_ff @(posedge clk_sd) begin
		if (rst) begin
			reset_count <= RESET_CYCLES;
			game_reset  <= 1'b1;
		end else begin
			if (!rom_loaded || reset_request)
				reset_count <= RESET_CYCLES;
			else if (reset_count != 16'd0)
				reset_count <= reset_count - 16'd1;
			// One more cycle here, the game sees reset drop RESET_CYCLES+1 after reload
			game_reset <= (reset_count != 16'd0);
		end
	end

endmodule

//--- sdram_port_writer.sv
/*
 * SDRAM port writer
 * Turns decoded download commands into toggle requests on SDRAM
 * ports 1 and 2 and a write pulse for the palette and sprite LUT
 */
`timescale 1ns/10ps

module sdram_port_writer (
	input  logic                   clk_sd,
	input  logic                   rst,
	input  rom_load_pkg::dl_cmd_t  cmd,
	output logic                   port1_req,
	output logic                   port2_req,
	output logic                   pal_strobe,
	output rom_load_pkg::port_wr_t port1_wr,
	output rom_load_pkg::port_wr_t port2_wr,
	output rom_load_pkg::pal_wr_t  pal_wr
);
	import rom_load_pkg::*;

	logic is_port1;
	logic is_port2;
	logic is_pal;

	always_comb begin
		is_port1 = 1'b0;
		is_port2 = 1'b0;
		is_pal   = 1'b0;
		if (cmd.valid) begin
			case (cmd.region)
				region_main, region_sound, region_tile: is_port1 = 1'b1;
				region_sprite:                          is_port2 = 1'b1;
				region_pal:                             is_pal   = 1'b1;
				default:                                ;
			endcase
		end
	end

	// ======================================================================
	// Request toggles and palette pulse
	// ======================================================================

	always_ff @(posedge clk_sd) begin
		if (rst) begin
			port1_req  <= 1'b0;
			port2_req  <= 1'b0;
			pal_strobe <= 1'b0;
		end else begin
			// The SDRAM controller sees a new request on every edge of req
			if (is_port1)
				port1_req <= ~port1_req;
			if (is_port2)
				port2_req <= ~port2_req;
			pal_strobe <= is_pal;
		end
	end

	// ======================================================================
	// Write payloads
	// ======================================================================

	// Port 1 is 16 bits wide, address bit 0 picks the byte lane
	always_ff @(posedge clk_sd) begin
		if (is_port1) begin
			port1_wr.addr <= cmd.addr.linear[23:1];
			port1_wr.ds   <= {cmd.addr.linear[0], ~cmd.addr.linear[0]};
			port1_wr.data <= {cmd.data, cmd.data};
		end
	end

	// The half bit becomes the lowest word address bit, so the two halves
	// of the sprite set land in consecutive words and read back as 32 bits
	always_ff @(posedge clk_sd) begin
		if (is_port2) begin
			port2_wr.addr <= {cmd.addr.spr.upper[7:0], cmd.addr.spr.offset,
				cmd.addr.spr.half};
			port2_wr.ds   <= {cmd.addr.spr.lane, ~cmd.addr.spr.lane};
			port2_wr.data <= {cmd.data, cmd.data};
		end
	end

	always_ff @(posedge clk_sd) begin
		if (is_pal) begin
			pal_wr.addr <= cmd.addr.linear[16:0];
			pal_wr.data <= cmd.data;
		end
	end

endmodule

//--- rom_region_decode.sv
/*
 * Download byte decoder
 * Samples the download stream, detects the rising edge of the write
 * strobe and sorts each accepted byte into a ROM region
 */
`timescale 1ns/10ps

module rom_region_decode (
	input  logic                  clk_sd,
	input  logic                  rst,
	input  logic                  download,
	input  logic                  wr,
	input  logic [24:0]           addr,
	input  logic [7:0]            data,
	output rom_load_pkg::dl_cmd_t cmd
);
	import rom_load_pkg::*;

	logic        download_q;
	logic        wr_q;
	logic        wr_prev;
	logic [24:0] addr_q;
	logic [7:0]  data_q;
	logic        accept;
	dl_cmd_t     cmd_next;

	// Input stage for the download level and the write strobe history
	always_ff @(posedge clk_sd) begin
		if (rst) begin
			download_q <= 1'b0;
			wr_q       <= 1'b0;
			wr_prev    <= 1'b0;
		end else begin
			download_q <= download;
			wr_q       <= wr;
			wr_prev    <= wr_q;
		end
	end

	always_ff @(posedge clk_sd) begin
		addr_q <= addr;
		data_q <= data;
	end

	// A byte counts once per low-to-high transition of wr
	assign accept = download_q & wr_q & ~wr_prev;

	// ======================================================================
	// Region classification
	// ======================================================================

	always_comb begin
		cmd_next             = '0;
		cmd_next.data        = data_q;
		cmd_next.addr.linear = addr_q;

		if (addr_q < snd_base) begin
			cmd_next.region = region_main;
		end else if (addr_q < tile_base) begin
			cmd_next.region = region_sound;
		end else if (addr_q < spr_base) begin
			cmd_next.region = region_tile;
		end else if (addr_q < pal_base) begin
			cmd_next.region = region_sprite;
			// Sprite bytes are addressed relative to the first sprite ROM
			cmd_next.addr.linear = addr_q - spr_base;
		end else if (addr_q <= pal_end) begin
			cmd_next.region = region_pal;
		end else begin
			cmd_next.region = region_none;
		end

		cmd_next.valid = accept && (cmd_next.region != region_none);
	end

	always_ff @(posedge clk_sd) begin
		if (rst) begin
			cmd.valid <= 1'b0;
		end else begin
			cmd <= cmd_next;
		end
	end

endmodule

//--- rom_load_pkg.sv
/*
 * Shared definitions for the ROM download path
 *   rom_region_e  destination of a downloaded byte
 *   dl_addr_u     download address, linear or sprite view
 *   dl_cmd_t      decoded download command
 *   port_wr_t     SDRAM port write word
 *   pal_wr_t      palette and sprite LUT write
 */
package rom_load_pkg;

	// ======================================================================
	// ROM map
	// ======================================================================

	// 00000-07FFF main CPU, 08000-09FFF sound CPU, 0A000-0FFFF tiles
	localparam logic [24:0] snd_base  = 25'h000_8000;
	localparam logic [24:0] tile_base = 25'h000_A000;

	// 10000-1BFFF sprite graphics, six ROMs merged into 32-bit words
	localparam logic [24:0] spr_base  = 25'h001_0000;

	// 1C000-1C31F character palette, sprite palette and sprite LUT
	localparam logic [24:0] pal_base  = 25'h001_C000;
	localparam logic [24:0] pal_end   = 25'h001_C31F;

	typedef enum logic [2:0] {
		region_main   = 3'd0,
		region_sound  = 3'd1,
		region_tile   = 3'd2,
		region_sprite = 3'd3,
		region_pal    = 3'd4,
		region_none   = 3'd7
	} rom_region_e;

	// ======================================================================
	// Download address views
	// ======================================================================

	// Sprite view, valid only once the sprite base has been removed
	typedef struct packed {
		logic [8:0]  upper;
		logic        half;
		logic        lane;
		logic [13:0] offset;
	} spr_addr_t;

	typedef union packed {
		logic [24:0] linear;
		spr_addr_t   spr;
	} dl_addr_u;

	typedef struct packed {
		logic        valid;
		rom_region_e region;
		dl_addr_u    addr;
		logic [7:0]  data;
	} dl_cmd_t;

	// ======================================================================
	// Write ports
	// ======================================================================

	typedef struct packed {
		logic [22:0] addr;
		logic [1:0]  ds;
		logic [15:0] data;
	} port_wr_t;

	typedef struct packed {
		logic [16:0] addr;
		logic [7:0]  data;
	} pal_wr_t;

endpackage
